// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = icache_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# output shown on stderr, status taken from the search for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/icache_tb.sv ====
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // kinds of request
  localparam int HIT  = 0;
  localparam int MISS = 1;
  localparam int UNC  = 2;

  localparam int          TIMEOUT_CYCLES = 200;
  localparam logic [31:0] NOP_WORD       = 32'h0000_0013;
  localparam logic [3:0]  EXP_SIZE       = 4'd4;

  // one cacheable line that reads back as zeros
  localparam logic [31:0] ZERO_LO = 32'h0000_3000;
  localparam logic [31:0] ZERO_HI = 32'h0000_3040;

  wire         clk;
  wire         rst;
  logic [31:0] fetch_addr_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_data_o;
  logic        fetch_data_valid_o;
  logic [31:0] mem_addr_o;
  logic        mem_addr_valid_o;
  logic [7:0]  mem_len_o;
  logic [3:0]  mem_size_o;
  logic        mem_rdata_ready_i = 1'b0;
  logic [31:0] mem_rdata_i = '0;

  // memory model state
  integer seed = 35264;
  integer rnd;
  logic   valid_prev = 1'b0;
  int     xfer_beat = 0;
  int     total_beats = 0;
  int     total_bursts = 0;

  // expectations of the request in flight
  string       test_name = "none";
  logic        started = 1'b0;
  logic        expect_hit = 1'b0;
  logic [31:0] exp_data = '0;
  logic [31:0] exp_addr = '0;
  logic [7:0]  exp_len = '0;
  int          exp_bursts = 0;
  int          exp_beats = 0;
  int          bursts_at_start = 0;
  int          beats_at_start = 0;

  int   errors = 0;
  int   timeouts = 0;
  logic timed_out = 1'b0;

  tb_clock_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  icache_top #(
    .UNCACHED_REGION (4'hA)
  ) DUT (
    .clk                (clk),
    .rst                (rst),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_data_o       (fetch_data_o),
    .fetch_data_valid_o (fetch_data_valid_o),
    .mem_addr_o         (mem_addr_o),
    .mem_addr_valid_o   (mem_addr_valid_o),
    .mem_len_o          (mem_len_o),
    .mem_size_o         (mem_size_o),
    .mem_rdata_ready_i  (mem_rdata_ready_i),
    .mem_rdata_i        (mem_rdata_i)
  );

  // backing memory contents
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [15:0] upper;
    logic [15:0] lower;
    if (a >= ZERO_LO && a < ZERO_HI) begin
      return 32'h0000_0000;
    end
    // upper half always opens a 32-bit instruction
    upper = a[15:0] | 16'h0003;
    // lower half is 32-bit only when bit 4 is set
    lower = {a[15:2], a[4], a[4]};
    return {upper, lower};
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = mem_word({a[31:2], 2'b00});
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // instruction at a halfword address, as the fetch port returns it
  function automatic logic [31:0] expect_cached(input logic [31:0] a);
    logic [15:0] cur;
    logic [31:0] r;
    cur = half_at(a);
    if (cur[1:0] == 2'b11) begin
      r = {half_at(a + 32'd2), cur};
    end else begin
      r = {16'h0000, cur};
    end
    return (r == 32'h0) ? NOP_WORD : r;
  endfunction

  // memory model, bus inputs change between rising edges
  always @(negedge clk) begin
    // beat taken at the rising edge just passed
    if (valid_prev && mem_rdata_ready_i) begin
      total_beats = total_beats + 1;
      xfer_beat = xfer_beat + 1;
    end
    if (mem_addr_valid_o && !valid_prev) begin
      total_bursts = total_bursts + 1;
      xfer_beat = 0;
    end
    valid_prev = mem_addr_valid_o;
    rnd = $random(seed);
    // ready about three cycles in four
    mem_rdata_ready_i = (rnd[1:0] != 2'b00);
    if (mem_addr_valid_o) begin
      mem_rdata_i = mem_word(mem_addr_o + 32'(4 * xfer_beat));
    end else begin
      mem_rdata_i = '0;
    end
  end

  // checks, sampled mid-cycle where outputs are settled
  a_quiet_after_reset: assert property (
    @(negedge clk) disable iff (rst)
    !started |-> !mem_addr_valid_o && !fetch_data_valid_o
  ) else begin
    errors++;
    $display("bus valid or result valid went high before the first request");
  end

  a_data: assert property (
    @(negedge clk) disable iff (rst)
    fetch_data_valid_o |-> fetch_data_o == exp_data
  ) else begin
    errors++;
    $display("Mismatch %s data expected %h actual %h", test_name, exp_data, fetch_data_o);
  end

  // hit result in the cycle right after acceptance
  a_hit_latency: assert property (
    @(negedge clk) disable iff (rst)
    fetch_valid_i && expect_hit |-> fetch_data_valid_o
  ) else begin
    errors++;
    $display("%s: no result in the cycle after acceptance", test_name);
  end

  a_hit_no_bus: assert property (
    @(negedge clk) disable iff (rst)
    expect_hit |-> !mem_addr_valid_o
  ) else begin
    errors++;
    $display("%s: bus transfer started on a hit", test_name);
  end

  a_addr: assert property (
    @(negedge clk) disable iff (rst)
    $rose(mem_addr_valid_o) |-> mem_addr_o == exp_addr
  ) else begin
    errors++;
    $display("Mismatch %s bus address expected %h actual %h", test_name, exp_addr, mem_addr_o);
  end

  a_len: assert property (
    @(negedge clk) disable iff (rst)
    $rose(mem_addr_valid_o) |-> mem_len_o == exp_len
  ) else begin
    errors++;
    $display("Mismatch %s bus length expected %0d actual %0d", test_name, exp_len, mem_len_o);
  end

  a_size: assert property (
    @(negedge clk) disable iff (rst)
    $rose(mem_addr_valid_o) |-> mem_size_o == EXP_SIZE
  ) else begin
    errors++;
    $display("Mismatch %s bus size expected %0d actual %0d", test_name, EXP_SIZE, mem_size_o);
  end

  // counts settle one cycle after the result
  a_bursts: assert property (
    @(negedge clk) disable iff (rst)
    fetch_data_valid_o |=> (total_bursts - bursts_at_start) == exp_bursts
  ) else begin
    errors++;
    $display("Mismatch %s bursts expected %0d actual %0d", test_name, exp_bursts,
             total_bursts - bursts_at_start);
  end

  a_beats: assert property (
    @(negedge clk) disable iff (rst)
    fetch_data_valid_o |=> (total_beats - beats_at_start) == exp_beats
  ) else begin
    errors++;
    $display("Mismatch %s beats expected %0d actual %0d", test_name, exp_beats,
             total_beats - beats_at_start);
  end

  // one request, held valid for the accepting edge only
  task automatic fetch(input string name, input logic [31:0] addr, input int kind);
    int cycles;
    if (!timed_out) begin
      @(negedge clk);
      test_name = name;
      expect_hit = (kind == HIT);
      bursts_at_start = total_bursts;
      beats_at_start = total_beats;
      if (kind == UNC) begin
        exp_bursts = 1;
        exp_beats = 1;
        exp_addr = {addr[31:2], 2'b00};
        exp_len = 8'd0;
        exp_data = mem_word(exp_addr);
      end else begin
        exp_bursts = (kind == MISS) ? 1 : 0;
        exp_beats = (kind == MISS) ? 16 : 0;
        exp_addr = {addr[31:6], 6'b000000};
        exp_len = 8'd15;
        exp_data = expect_cached(addr);
      end
      started = 1'b1;
      fetch_addr_i = addr;
      fetch_valid_i = 1'b1;
      @(negedge clk);
      fetch_valid_i = 1'b0;
      cycles = 0;
      while (!fetch_data_valid_o && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        cycles++;
      end
      if (!fetch_data_valid_o) begin
        timeouts++;
        timed_out = 1'b1;
        $display("timeout: no fetch result for %s within %0d cycles", name, TIMEOUT_CYCLES);
      end else begin
        // one quiet cycle so the count checks see this request
        @(negedge clk);
      end
    end
  endtask

  initial begin
    int cycles;
    int off;
    fetch_addr_i = '0;
    fetch_valid_i = 1'b0;
    cycles = 0;
    // reset still unknown at time zero counts as asserted
    while (rst !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end
    // idle stretch, nothing may move on the bus
    repeat (6) @(negedge clk);

    fetch("miss_16bit", 32'h0000_1040, MISS);
    // every other halfword of the line, offset 62 left out
    for (off = 2; off < 62; off += 2) begin
      fetch($sformatf("hit_sweep_%0h", 32'h0000_1040 + off), 32'h0000_1040 + 32'(off), HIT);
    end
    fetch("hit_same_addr", 32'h0000_1040, HIT);
    fetch("miss_32bit", 32'h0000_2090, MISS);
    fetch("hit_after_32bit_miss", 32'h0000_20A2, HIT);

    // uncached space always goes to the bus
    fetch("uncached_first", 32'hA000_0104, UNC);
    fetch("uncached_repeat", 32'hA000_0104, UNC);
    fetch("uncached_upper_half", 32'hA000_0106, UNC);

    fetch("zero_miss", 32'h0000_3000, MISS);
    fetch("zero_hit", 32'h0000_3006, HIT);

    // same index 5, tags differ
    fetch("evict_a", 32'h0000_0140, MISS);
    fetch("evict_b", 32'h0000_2140, MISS);
    fetch("evict_a_again", 32'h0000_0140, MISS);
    fetch("evict_a_hit", 32'h0000_0146, HIT);

    repeat (2) @(negedge clk);
    $display("failed checks: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`default_nettype none

// free running clock and power-on reset for the testbench
module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset covers two rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/icache_pkg.sv
verilog/refill_wr_if.sv
verilog/icache_lookup.sv
verilog/icache_refill_ctrl.sv
verilog/icache_data_array.sv
verilog/fetch_align.sv
verilog/icache_top.sv
bench/tb_clock_gen.sv
bench/icache_tb.sv

// ==== verilog/fetch_align.sv ====
`default_nettype none

module fetch_align (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               half_i,
  input  wire [icache_pkg::WORD_W-1:0]      rd_word_i,
  input  wire [icache_pkg::WORD_W-1:0]      rd_next_i,
  input  wire                               hit_done_i,
  input  wire                               uncached_done_i,
  input  wire [icache_pkg::WORD_W-1:0]      uncached_data_i,
  output logic [icache_pkg::WORD_W-1:0]     fetch_data_o,
  output logic                              fetch_data_valid_o
);

  logic [15:0]                   cur_half;
  logic [15:0]                   up_half;
  logic                          is_32bit;
  logic [icache_pkg::WORD_W-1:0] aligned;
  logic [icache_pkg::WORD_W-1:0] cached_data;
  logic                          unc_valid_q;
  logic [icache_pkg::WORD_W-1:0] unc_data_q;

  // halfword at the fetch address
  assign cur_half = half_i ? rd_word_i[31:16] : rd_word_i[15:0];

  // halfword right above it, from the next word when in the upper half
  assign up_half = half_i ? rd_next_i[15:0] : rd_word_i[31:16];

  // low bits 11 mark a 32-bit instruction
  assign is_32bit = (cur_half[1:0] == 2'b11);

  assign aligned = is_32bit ? {up_half, cur_half} : {16'h0000, cur_half};

  // all zero result turns into a no-op
  assign cached_data = (aligned == '0) ? icache_pkg::NOP_INST : aligned;

  // uncached word held for one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      unc_valid_q <= 1'b0;
    end else begin
      unc_valid_q <= uncached_done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (uncached_done_i) begin
      unc_data_q <= uncached_data_i;
    end
  end

  // raw bus word passes unchanged
  assign fetch_data_o       = unc_valid_q ? unc_data_q : cached_data;
  assign fetch_data_valid_o = hit_done_i || unc_valid_q;

endmodule

`default_nettype wire

// ==== verilog/icache_data_array.sv ====
`default_nettype none

module icache_data_array (
  input  wire                               clk,
  refill_wr_if.slave                        wr,
  input  wire icache_pkg::line_idx_t        rd_line_i,
  input  wire icache_pkg::word_idx_t        rd_word_i,
  output logic [icache_pkg::WORD_W-1:0]     rd_word_o,
  output logic [icache_pkg::WORD_W-1:0]     rd_next_o
);

  // line by word storage
  logic [icache_pkg::WORD_W-1:0] mem [icache_pkg::NUM_LINES][icache_pkg::WORDS_PER_LINE];

  // following word inside the same line
  // wraps to word 0 at 15, only hit by the unsupported straddling fetch
  icache_pkg::word_idx_t next_word;

  assign next_word = rd_word_i + 1'b1;

  // write lands at the edge
  always_ff @(posedge clk) begin
    if (wr.wr_en) begin
      mem[wr.wr_line][wr.wr_word] <= wr.wr_data;
    end
  end

  // combinational reads
  assign rd_word_o = mem[rd_line_i][rd_word_i];
  assign rd_next_o = mem[rd_line_i][next_word];

endmodule

`default_nettype wire

// ==== verilog/icache_lookup.sv ====
`default_nettype none

module icache_lookup #(
  parameter logic [3:0] UNCACHED_REGION = 4'hA
) (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               capture_i,
  input  wire                               tag_write_i,
  input  wire [icache_pkg::ADDR_W-1:0]      fetch_addr_i,
  output icache_pkg::tag_t                  tag_o,
  output icache_pkg::line_idx_t             line_o,
  output icache_pkg::word_idx_t             word_o,
  output logic                              half_o,
  output logic                              hit_o,
  output logic                              uncached_o
);

  localparam int A_W   = icache_pkg::ADDR_W;
  localparam int OFF_W = icache_pkg::OFFSET_W;
  localparam int IDX_W = icache_pkg::INDEX_W;

  // registered address fields
  icache_pkg::tag_t      tag_q;
  icache_pkg::line_idx_t line_q;
  icache_pkg::word_idx_t word_q;
  logic                  half_q;

  // tag store, valid bits kept apart so reset can clear them
  icache_pkg::tag_t                    tag_mem [icache_pkg::NUM_LINES];
  logic [icache_pkg::NUM_LINES-1:0]    valid_q;

  // address taken only at acceptance
  always_ff @(posedge clk) begin
    if (capture_i) begin
      tag_q  <= fetch_addr_i[A_W-1 -: icache_pkg::TAG_W];
      line_q <= fetch_addr_i[OFF_W +: IDX_W];
      word_q <= fetch_addr_i[OFF_W-1:2];
      half_q <= fetch_addr_i[1];
    end
  end

  // tag written at the last refill beat
  always_ff @(posedge clk) begin
    if (tag_write_i) begin
      tag_mem[line_q] <= tag_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_write_i) begin
      valid_q[line_q] <= 1'b1;
    end
  end

  // top nibble selects the uncached region
  assign uncached_o = (tag_q[icache_pkg::TAG_W-1 -: 4] == UNCACHED_REGION);

  // uncached space never hits, even on a stale tag
  assign hit_o = valid_q[line_q] && (tag_mem[line_q] == tag_q) && !uncached_o;

  assign tag_o  = tag_q;
  assign line_o = line_q;
  assign word_o = word_q;
  assign half_o = half_q;

  // refill only for cacheable space, and the retried lookup must hit
  a_tag_write_hits: assert property (
    @(posedge clk) disable iff (rst)
    tag_write_i |-> !uncached_o ##1 hit_o
  ) else $error("tag write on uncached address or no hit after refill");

endmodule

`default_nettype wire

// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // bus and fetch widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // address split: tag | line index | block offset
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 7;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // 64 byte line holds sixteen 32-bit words
  localparam int WORD_IDX_W     = OFFSET_W - 2;
  localparam int WORDS_PER_LINE = 1 << WORD_IDX_W;

  // 128 lines, 8 KB in total
  localparam int NUM_LINES = 1 << INDEX_W;

  // address field types shared by lookup, controller and data array
  typedef logic [INDEX_W-1:0]    line_idx_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;
  typedef logic [TAG_W-1:0]      tag_t;

  // controller states
  // RESET is held for one cycle after rst drops
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED_READ
  } ctrl_state_t;

  // bus transfer size code, 4 means 32 bits per beat
  localparam logic [3:0] SIZE_WORD = 4'd4;

  // addi x0, x0, 0
  // returned in place of an all-zero fetch result
  localparam logic [WORD_W-1:0] NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== verilog/icache_refill_ctrl.sv ====
`default_nettype none

module icache_refill_ctrl (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               fetch_valid_i,
  input  wire                               hit_i,
  input  wire                               uncached_i,
  input  wire icache_pkg::tag_t             tag_i,
  input  wire icache_pkg::line_idx_t        line_i,
  input  wire icache_pkg::word_idx_t        addr_word_i,
  output logic                              capture_o,
  output logic                              tag_write_o,
  output logic                              hit_done_o,
  output logic                              uncached_done_o,
  output logic [icache_pkg::WORD_W-1:0]     uncached_data_o,
  output logic [icache_pkg::ADDR_W-1:0]     mem_addr_o,
  output logic                              mem_addr_valid_o,
  output logic [7:0]                        mem_len_o,
  output logic [3:0]                        mem_size_o,
  input  wire                               mem_rdata_ready_i,
  input  wire [icache_pkg::WORD_W-1:0]      mem_rdata_i,
  refill_wr_if.master                       wr
);

  localparam icache_pkg::word_idx_t LAST_WORD =
    icache_pkg::word_idx_t'(icache_pkg::WORDS_PER_LINE - 1);

  icache_pkg::ctrl_state_t state_q;
  icache_pkg::word_idx_t   beat_cnt_q;
  logic                    mem_valid_q;
  logic                    beat;
  logic                    last_beat;
  logic                    start_bus;

  // one beat per cycle with valid and ready both high
  assign beat = mem_valid_q && mem_rdata_ready_i;

  // final beat of either transfer kind
  assign last_beat = beat && ((state_q == icache_pkg::REFILL && beat_cnt_q == LAST_WORD) ||
                              state_q == icache_pkg::UNCACHED_READ);

  // lookup cycle that misses or lands in uncached space
  assign start_bus = (state_q == icache_pkg::LOOKUP) && !hit_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= icache_pkg::RESET;
      beat_cnt_q  <= '0;
      mem_valid_q <= 1'b0;
    end else begin
      case (state_q)
        icache_pkg::RESET: begin
          state_q <= icache_pkg::IDLE;
        end
        icache_pkg::IDLE: begin
          if (fetch_valid_i) begin
            state_q <= icache_pkg::LOOKUP;
          end
        end
        icache_pkg::LOOKUP: begin
          if (hit_i) begin
            state_q <= icache_pkg::IDLE;
          end else if (uncached_i) begin
            state_q     <= icache_pkg::UNCACHED_READ;
            mem_valid_q <= 1'b1;
          end else begin
            state_q     <= icache_pkg::REFILL;
            mem_valid_q <= 1'b1;
            beat_cnt_q  <= '0;
          end
        end
        icache_pkg::REFILL: begin
          if (last_beat) begin
            // retry the lookup, which now hits
            state_q     <= icache_pkg::LOOKUP;
            mem_valid_q <= 1'b0;
          end else if (beat) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
        end
        icache_pkg::UNCACHED_READ: begin
          if (last_beat) begin
            state_q     <= icache_pkg::IDLE;
            mem_valid_q <= 1'b0;
          end
        end
        default: begin
          state_q <= icache_pkg::IDLE;
        end
      endcase
    end
  end

  // request fields held for the whole transfer
  always_ff @(posedge clk) begin
    if (start_bus) begin
      mem_size_o <= icache_pkg::SIZE_WORD;
      if (uncached_i) begin
        // word aligned single beat
        mem_addr_o <= {tag_i, line_i, addr_word_i, 2'b00};
        mem_len_o  <= 8'd0;
      end else begin
        // line aligned burst of 16
        mem_addr_o <= {tag_i, line_i, {icache_pkg::OFFSET_W{1'b0}}};
        mem_len_o  <= 8'(icache_pkg::WORDS_PER_LINE - 1);
      end
    end
  end

  assign mem_addr_valid_o = mem_valid_q;

  // request accepted when idle
  assign capture_o = (state_q == icache_pkg::IDLE) && fetch_valid_i;

  assign hit_done_o  = (state_q == icache_pkg::LOOKUP) && hit_i;
  assign tag_write_o = last_beat && (state_q == icache_pkg::REFILL);

  // bus word handed over with the done pulse
  assign uncached_done_o = last_beat && (state_q == icache_pkg::UNCACHED_READ);
  assign uncached_data_o = mem_rdata_i;

  // refill write, one word per beat at the counted slot
  assign wr.wr_en   = beat && (state_q == icache_pkg::REFILL);
  assign wr.wr_line = line_i;
  assign wr.wr_word = beat_cnt_q;
  assign wr.wr_data = mem_rdata_i;

  a_valid_held: assert property (
    @(posedge clk) disable iff (rst)
    mem_addr_valid_o && !last_beat |=> mem_addr_valid_o
  ) else $error("bus valid dropped before final beat");

  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    mem_addr_valid_o && !mem_rdata_ready_i |=>
      $stable(mem_addr_o) && $stable(mem_len_o) && $stable(mem_size_o)
  ) else $error("bus request changed while waiting for ready");

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
`default_nettype none

module icache_top #(
  parameter logic [3:0] UNCACHED_REGION = 4'hA
) (
  input  wire                               clk,
  input  wire                               rst,
  // fetch side
  input  wire [icache_pkg::ADDR_W-1:0]      fetch_addr_i,
  input  wire                               fetch_valid_i,
  output logic [icache_pkg::WORD_W-1:0]     fetch_data_o,
  output logic                              fetch_data_valid_o,
  // memory side
  output logic [icache_pkg::ADDR_W-1:0]     mem_addr_o,
  output logic                              mem_addr_valid_o,
  output logic [7:0]                        mem_len_o,
  output logic [3:0]                        mem_size_o,
  input  wire                               mem_rdata_ready_i,
  input  wire [icache_pkg::WORD_W-1:0]      mem_rdata_i
);

  // lookup results
  icache_pkg::tag_t      tag;
  icache_pkg::line_idx_t line;
  icache_pkg::word_idx_t word;
  logic                  half;
  logic                  hit;
  logic                  uncached;

  // controller strobes
  logic                  capture;
  logic                  tag_write;
  logic                  hit_done;
  logic                  uncached_done;
  logic [icache_pkg::WORD_W-1:0] uncached_data;

  // data array read words
  logic [icache_pkg::WORD_W-1:0] rd_word;
  logic [icache_pkg::WORD_W-1:0] rd_next;

  refill_wr_if u_refill_wr ();

  icache_lookup #(
    .UNCACHED_REGION (UNCACHED_REGION)
  ) u_lookup (
    .clk          (clk),
    .rst          (rst),
    .capture_i    (capture),
    .tag_write_i  (tag_write),
    .fetch_addr_i (fetch_addr_i),
    .tag_o        (tag),
    .line_o       (line),
    .word_o       (word),
    .half_o       (half),
    .hit_o        (hit),
    .uncached_o   (uncached)
  );

  icache_refill_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .fetch_valid_i     (fetch_valid_i),
    .hit_i             (hit),
    .uncached_i        (uncached),
    .tag_i             (tag),
    .line_i            (line),
    .addr_word_i       (word),
    .capture_o         (capture),
    .tag_write_o       (tag_write),
    .hit_done_o        (hit_done),
    .uncached_done_o   (uncached_done),
    .uncached_data_o   (uncached_data),
    .mem_addr_o        (mem_addr_o),
    .mem_addr_valid_o  (mem_addr_valid_o),
    .mem_len_o         (mem_len_o),
    .mem_size_o        (mem_size_o),
    .mem_rdata_ready_i (mem_rdata_ready_i),
    .mem_rdata_i       (mem_rdata_i),
    .wr                (u_refill_wr.master)
  );

  icache_data_array u_data (
    .clk       (clk),
    .wr        (u_refill_wr.slave),
    .rd_line_i (line),
    .rd_word_i (word),
    .rd_word_o (rd_word),
    .rd_next_o (rd_next)
  );

  fetch_align u_align (
    .clk                (clk),
    .rst                (rst),
    .half_i             (half),
    .rd_word_i          (rd_word),
    .rd_next_i          (rd_next),
    .hit_done_i         (hit_done),
    .uncached_done_i    (uncached_done),
    .uncached_data_i    (uncached_data),
    .fetch_data_o       (fetch_data_o),
    .fetch_data_valid_o (fetch_data_valid_o)
  );

endmodule

`default_nettype wire

// ==== verilog/refill_wr_if.sv ====
`default_nettype none

// refill write path, one word per cycle with wr_en high
// no acknowledge, the array always accepts
interface refill_wr_if;

  logic                             wr_en;
  icache_pkg::line_idx_t            wr_line;
  icache_pkg::word_idx_t            wr_word;
  logic [icache_pkg::WORD_W-1:0]    wr_data;

  // controller side
  modport master (
    output wr_en,
    output wr_line,
    output wr_word,
    output wr_data
  );

  // data array side
  modport slave (
    input wr_en,
    input wr_line,
    input wr_word,
    input wr_data
  );

endinterface

`default_nettype wire
